//--- files.f
hdl/usb_phy_pkg.sv
hdl/usb_tx_phy.sv
hdl/usb_rx_line.sv
hdl/usb_rx_decode.sv
hdl/usb_phy.sv
tests/usb_phy_props.sv
tests/tb_usb_phy.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_usb_phy
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_usb_phy.sv
`timescale 1ns/10ps

module tb_usb_phy;
	import usb_phy_pkg::*;

	localparam int RST_CNT_W = 5;
	localparam int NUM_PKT   = 6;
	localparam int CLK_NS    = 8;
	// Worst packet in symbols with stuffing, end of packet and idle gap
	localparam int PKT_SYMS  = 8 + 64 + 11 + 3 + 16;
	localparam int LIMIT_NS  = (2 * NUM_PKT + 4) * PKT_SYMS * BIT_CLKS * CLK_NS * 2
		+ ((1 << RST_CNT_W) + 16) * BIT_CLKS * CLK_NS;

	typedef logic [1:0] sym_q_t[$];
	typedef logic bit_q_t[$];
	typedef byte_t byte_q_t[$];

	logic        clk;
	logic        rst;
	utmi_tx_t    tx;
	logic        tx_ready;
	usb_line_t   line;
	logic        rxdp;
	logic        rxdn;
	utmi_rx_t    rx;
	line_state_e line_state;
	logic        usb_rst;
	logic [31:0] lfsr;
	byte_q_t     exp_bytes;
	logic        cmp_en;
	int          err_cnt;
	int          rst_seen;
	int          ready_cnt;

	usb_phy #(
		.RST_CNT_W (RST_CNT_W)
	) dut_i (
		.clk          (clk),
		.rst          (rst),
		.i_tx         (tx),
		.o_tx_ready   (tx_ready),
		.o_line       (line),
		.i_rxdp       (rxdp),
		.i_rxdn       (rxdn),
		.o_rx         (rx),
		.o_line_state (line_state),
		.o_usb_rst    (usb_rst)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("error at %0t: %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1, "%s", msg);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "%s", name);
		end
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Reference encoder
	function automatic bit_q_t packet_bits(input byte_q_t data);
		bit_q_t bits;
		for (int b = 0; b < 8; b++)
			bits.push_back(SYNC_BYTE[b]);
		foreach (data[n])
			for (int b = 0; b < 8; b++)
				bits.push_back(data[n][b]);
		return bits;
	endfunction

	// Zero toggles the level, idle J before the first bit
	function automatic sym_q_t nrzi_encode(input bit_q_t bits, input logic stuff_on);
		sym_q_t syms;
		logic   level;
		int     ones;
		level = 1'b1;
		ones  = 0;
		foreach (bits[i])
		begin
			if (!bits[i])
				level = !level;
			ones = bits[i] ? ones + 1 : 0;
			syms.push_back(level ? LS_J : LS_K);
			if (stuff_on && ones == STUFF_RUN)
			begin
				level = !level;
				ones  = 0;
				syms.push_back(level ? LS_J : LS_K);
			end
		end
		syms.push_back(LS_SE0);
		syms.push_back(LS_SE0);
		syms.push_back(LS_J);
		return syms;
	endfunction

	task automatic make_packet(input logic force_ff, output byte_q_t data);
		logic [31:0] v;
		int          len;
		data = {};
		rand_bits(3, v);
		len = int'(v[2:0]) + 1;
		for (int n = 0; n < len; n++)
		begin
			rand_bits(8, v);
			data.push_back((force_ff && n < 2) ? 8'hff : v[7:0]);
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Transmit side
	task automatic drive_tx(input byte_q_t data);
		@(negedge clk);
		tx.valid = 1'b1;
		tx.data  = data[0];
		foreach (data[n])
		begin
			do
				@(negedge clk);
			while (!tx_ready);
			// Byte is taken on the edge that ends the pulse
			@(negedge clk);
			if (n + 1 < data.size())
				tx.data = data[n + 1];
			else
				tx.valid = 1'b0;
		end
	endtask

	task automatic capture_line(output sym_q_t got);
		got = {};
		do
			@(negedge clk);
		while (line.oe_n);
		repeat (BIT_CLKS / 2) @(negedge clk);
		while (!line.oe_n)
		begin
			got.push_back({line.dn, line.dp});
			repeat (BIT_CLKS) @(negedge clk);
		end
	endtask

	task automatic send_packet(input byte_q_t data);
		sym_q_t exp_syms;
		sym_q_t got;
		exp_syms  = nrzi_encode(packet_bits(data), 1'b1);
		ready_cnt = 0;
		fork
			drive_tx(data);
			capture_line(got);
		join
		// Idle J can lead the sync pattern
		while (got.size() > 0 && got[0] == LS_J)
			void'(got.pop_front());
		if (got.size() < exp_syms.size())
			report_failure("transmitted packet is shorter than the reference");
		foreach (exp_syms[i])
			check("o_line", 32'(got[i]), 32'(exp_syms[i]));
		for (int i = exp_syms.size(); i < got.size(); i++)
			check("o_line", 32'(got[i]), 32'(LS_J));
		check("o_tx_ready count", 32'(ready_cnt), 32'(data.size()));
	endtask

	task automatic receive_packet(input sym_q_t syms);
		foreach (syms[i])
		begin
			{rxdn, rxdp} = syms[i];
			repeat (BIT_CLKS) @(negedge clk);
		end
		repeat (8 * BIT_CLKS) @(negedge clk);
	endtask

	// Compares received bytes as they arrive
	always @(negedge clk)
	begin
		if (tx_ready)
			ready_cnt++;
		if (rx.error)
			err_cnt++;
		if (usb_rst)
			rst_seen++;
		if (rx.valid && cmp_en)
		begin
			if (exp_bytes.size() == 0)
				report_failure("o_rx.valid pulsed with no byte outstanding");
			else
				check("o_rx.data", 32'(rx.data), 32'(exp_bytes.pop_front()));
		end
	end

	initial
	begin
		#(LIMIT_NS);
		$display("timeout after %0d ns, the tests did not finish", LIMIT_NS);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		byte_q_t data;
		bit_q_t  bits;
		lfsr     = 32'h12b9_bcb8;
		rst      = 1'b0;
		tx       = '0;
		rxdp     = 1'b1;
		rxdn     = 1'b0;
		cmp_en   = 1'b0;
		err_cnt  = 0;
		rst_seen = 0;
		repeat (5) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		check("o_line", 32'(line), 32'(3'b101));
		check("o_tx_ready", 32'(tx_ready), 32'd0);
		check("o_rx.valid", 32'(rx.valid), 32'd0);
		check("o_rx.active", 32'(rx.active), 32'd0);
		check("o_rx.error", 32'(rx.error), 32'd0);
		check("o_usb_rst", 32'(usb_rst), 32'd0);
		repeat (4 * BIT_CLKS) @(negedge clk);
		check("o_line_state", 32'(line_state), 32'(LS_J));

		for (int p = 0; p < NUM_PKT; p++)
		begin
			make_packet(p < 2, data);
			send_packet(data);
			repeat (4 * BIT_CLKS) @(negedge clk);
		end

		cmp_en   = 1'b1;
		err_cnt  = 0;
		rst_seen = 0;
		for (int p = 0; p < NUM_PKT; p++)
		begin
			make_packet(p == 0, data);
			foreach (data[n])
				exp_bytes.push_back(data[n]);
			receive_packet(nrzi_encode(packet_bits(data), 1'b1));
			check("bytes not received", 32'(exp_bytes.size()), 32'd0);
			check("o_rx.active", 32'(rx.active), 32'd0);
			check("o_rx.error count", 32'(err_cnt), 32'd0);
			check("o_usb_rst count", 32'(rst_seen), 32'd0);
		end

		// Seven ones in a row with no stuffed zero
		cmp_en  = 1'b0;
		err_cnt = 0;
		data    = {8'hff, 8'h00};
		bits    = packet_bits(data);
		receive_packet(nrzi_encode(bits, 1'b0));
		if (err_cnt == 0)
			report_failure("no o_rx.error pulse for a bit stuff error");
		check("o_rx.active", 32'(rx.active), 32'd0);

		{rxdn, rxdp} = 2'b00;
		repeat (((1 << RST_CNT_W) + 4) * BIT_CLKS) @(negedge clk);
		check("o_usb_rst", 32'(usb_rst), 32'd1);
		{rxdn, rxdp} = 2'b01;
		repeat (2 * BIT_CLKS) @(negedge clk);
		check("o_usb_rst", 32'(usb_rst), 32'd0);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- tests/usb_phy_props.sv
`timescale 1ns/10ps

module usb_phy_props #(
	parameter int RST_CNT_W = 5
) (
	input logic                     clk,
	input logic                     rst,
	input usb_phy_pkg::utmi_tx_t    i_tx,
	input logic                     o_tx_ready,
	input usb_phy_pkg::usb_line_t   o_line,
	input usb_phy_pkg::utmi_rx_t    o_rx,
	input usb_phy_pkg::line_state_e o_line_state,
	input logic                     o_usb_rst
);
	import usb_phy_pkg::*;

	// Bytes only arrive inside a packet
	a_valid_active: assert property (@(posedge clk) disable iff (!rst)
		o_rx.valid |-> o_rx.active)
		else $error("o_rx.valid seen while o_rx.active is low");

	a_ready_valid: assert property (@(posedge clk) disable iff (!rst)
		o_tx_ready |-> i_tx.valid)
		else $error("o_tx_ready pulsed without i_tx.valid");

	// Driven SE0 is the two bit end of packet, then J
	a_eop_len: assert property (@(posedge clk) disable iff (!rst)
		!o_line.oe_n && $fell(o_line.dp | o_line.dn)
		|-> ##(2 * BIT_CLKS - 1) (!o_line.dp && !o_line.dn)
		##1 (o_line.dp && !o_line.dn))
		else $error("end of packet SE0 is not two bit times followed by J");

	// Reset flag needs SE0 held for many bit times
	a_rst_on_se0: assert property (@(posedge clk) disable iff (!rst)
		o_usb_rst |-> $past(o_line_state, 2 << RST_CNT_W) == LS_SE0)
		else $error("o_usb_rst set without a long SE0 on the line");

endmodule

bind usb_phy usb_phy_props #(
	.RST_CNT_W (RST_CNT_W)
) props_i (
	.clk          (clk),
	.rst          (rst),
	.i_tx         (i_tx),
	.o_tx_ready   (o_tx_ready),
	.o_line       (o_line),
	.o_rx         (o_rx),
	.o_line_state (o_line_state),
	.o_usb_rst    (o_usb_rst)
);

//--- hdl/usb_phy.sv
`timescale 1ns/10ps

module usb_phy #(
	parameter int RST_CNT_W = 5
) (
	input  logic                     clk,
	input  logic                     rst,
	input  usb_phy_pkg::utmi_tx_t    i_tx,
	output logic                     o_tx_ready,
	output usb_phy_pkg::usb_line_t   o_line,
	input  logic                     i_rxdp,
	input  logic                     i_rxdn,
	output usb_phy_pkg::utmi_rx_t    o_rx,
	output usb_phy_pkg::line_state_e o_line_state,
	output logic                     o_usb_rst
);
	import usb_phy_pkg::*;

	// Bit centre enable shared by both directions
	logic     fs_ce;
	rx_line_t rx_line;

	usb_tx_phy tx_i (
		.clk        (clk),
		.rst        (rst),
		.i_fs_ce    (fs_ce),
		.i_tx       (i_tx),
		.o_tx_ready (o_tx_ready),
		.o_line     (o_line)
	);

	// Receiver listens only while the transmitter has released the bus
	usb_rx_line #(
		.RST_CNT_W (RST_CNT_W)
	) rx_line_i (
		.clk          (clk),
		.rst          (rst),
		.i_rxdp       (i_rxdp),
		.i_rxdn       (i_rxdn),
		.i_rx_en      (o_line.oe_n),
		.o_fs_ce      (fs_ce),
		.o_line       (rx_line),
		.o_line_state (o_line_state),
		.o_usb_rst    (o_usb_rst)
	);

	usb_rx_decode rx_decode_i (
		.clk          (clk),
		.rst          (rst),
		.i_fs_ce      (fs_ce),
		.i_line       (rx_line),
		.i_line_state (o_line_state),
		.i_rx_en      (o_line.oe_n),
		.o_rx         (o_rx)
	);

endmodule

//--- hdl/usb_rx_decode.sv
`timescale 1ns/10ps

module usb_rx_decode (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     i_fs_ce,
	input  usb_phy_pkg::rx_line_t    i_line,
	input  usb_phy_pkg::line_state_e i_line_state,
	input  logic                     i_rx_en,
	output usb_phy_pkg::utmi_rx_t    o_rx
);
	import usb_phy_pkg::*;

	localparam int ONE_W = $clog2(STUFF_RUN + 1);

	typedef enum logic [2:0] {FS_IDLE, K1, J1, K2, J2, K3, J3, K4} fs_state_e;

	fs_state_e        fs_state;
	fs_state_e        fs_next;
	logic             rx_en;
	logic             j;
	logic             k;
	logic             rxd;
	logic             se0_s;
	logic             synced_d;
	logic             sync_err_d;
	logic             sym_ok;
	logic             rx_active;
	logic             rx_valid_r;
	logic             sd_r;
	logic             sd_nrzi;
	logic [ONE_W-1:0] one_cnt;
	logic             drop_bit;
	logic             shift_en;
	logic [2:0]       bit_cnt;
	logic             rx_valid1;
	logic             rx_valid;
	logic             rx_error;
	byte_t            hold_reg;

	assign j   = i_line_state == LS_J;
	assign k   = i_line_state == LS_K;
	// SE1 reads as a zero
	assign rxd = i_line.dp & !i_line.dn;
	// Odd states are K and wait for J, even ones wait for K
	assign sym_ok   = rx_en && (fs_state[0] ? j : k);
	assign drop_bit = one_cnt == ONE_W'(STUFF_RUN);
	assign o_rx     = utmi_rx_t'{data: hold_reg, valid: rx_valid, active: rx_active,
		error: rx_error};

	////////////////////////////////////////////////////////////////////
	// Sync pattern search, KJKJKJKK
	always_comb
	begin
		fs_next    = fs_state;
		synced_d   = 1'b0;
		sync_err_d = 1'b0;
		if (i_fs_ce && !rx_active && !i_line.se0 && !se0_s)
			case (fs_state)
				FS_IDLE:
					if (k && rx_en)
						fs_next = K1;
				K3:
					if (j && rx_en)
						fs_next = J3;
					else if (k && rx_en)
					begin
						// First KJ pair lost
						synced_d = 1'b1;
						fs_next  = FS_IDLE;
					end
					else
					begin
						sync_err_d = 1'b1;
						fs_next    = FS_IDLE;
					end
				K4:
				begin
					synced_d = k;
					fs_next  = FS_IDLE;
				end
				default:
					if (sym_ok)
						fs_next = fs_state_e'(fs_state + 3'd1);
					else
					begin
						sync_err_d = 1'b1;
						fs_next    = FS_IDLE;
					end
			endcase
	end

	always_ff @(posedge clk or negedge rst)
		if (!rst)
		begin
			fs_state   <= FS_IDLE;
			rx_en      <= 1'b0;
			se0_s      <= 1'b0;
			rx_active  <= 1'b0;
			rx_valid_r <= 1'b0;
			rx_error   <= 1'b0;
		end
		else
		begin
			fs_state <= fs_next;
			rx_en    <= i_rx_en;
			if (i_fs_ce)
				se0_s <= i_line.se0;
			// Ends after the last byte, or when SE0 goes away on a broken packet
			if (synced_d && rx_en)
				rx_active <= 1'b1;
			else if ((i_line.se0 && rx_valid_r) || (se0_s && !i_line.se0))
				rx_active <= 1'b0;
			if (rx_valid)
				rx_valid_r <= 1'b1;
			else if (i_fs_ce)
				rx_valid_r <= 1'b0;
			rx_error <= (sync_err_d && !rx_active)
				|| (drop_bit && sd_nrzi && i_fs_ce && !i_line.se0 && rx_active);
		end

	////////////////////////////////////////////////////////////////////
	// NRZI decode, destuffing and byte assembly
	always_ff @(posedge clk or negedge rst)
		if (!rst)
		begin
			sd_r      <= 1'b1;
			sd_nrzi   <= 1'b0;
			one_cnt   <= '0;
			shift_en  <= 1'b0;
			bit_cnt   <= '0;
			rx_valid1 <= 1'b0;
			rx_valid  <= 1'b0;
		end
		else
		begin
			if (i_fs_ce)
				sd_r <= rxd;
			// No transition means a one
			if (!rx_active)
				sd_nrzi <= 1'b1;
			else if (i_fs_ce)
				sd_nrzi <= !(rxd ^ sd_r);
			if (i_fs_ce)
				shift_en <= synced_d | rx_active;
			if (!shift_en)
			begin
				one_cnt <= '0;
				bit_cnt <= '0;
			end
			else if (i_fs_ce)
			begin
				one_cnt <= (!sd_nrzi || drop_bit) ? '0 : one_cnt + ONE_W'(1);
				if (!drop_bit)
					bit_cnt <= bit_cnt + 3'd1;
			end
			if (i_fs_ce && !drop_bit && bit_cnt == 3'd7)
				rx_valid1 <= 1'b1;
			else if (rx_valid1 && i_fs_ce && !drop_bit)
				rx_valid1 <= 1'b0;
			rx_valid <= rx_valid1 && i_fs_ce && !drop_bit && rx_active;
		end

	always_ff @(posedge clk)
		if (i_fs_ce && shift_en && !drop_bit)
			hold_reg <= {sd_nrzi, hold_reg[7:1]};

endmodule

//--- hdl/usb_rx_line.sv
`timescale 1ns/10ps

module usb_rx_line #(
	parameter int RST_CNT_W = 5
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     i_rxdp,
	input  logic                     i_rxdn,
	input  logic                     i_rx_en,
	output logic                     o_fs_ce,
	output usb_phy_pkg::rx_line_t    o_line,
	output usb_phy_pkg::line_state_e o_line_state,
	output logic                     o_usb_rst
);
	import usb_phy_pkg::*;

	localparam int DPLL_W = $clog2(BIT_CLKS);

	// Bit 1 is D-, bit 0 is D+
	logic [1:0]           sync0;
	logic [1:0]           sync1;
	logic [1:0]           filt;
	logic                 rxd_r;
	logic                 lock_en;
	logic                 change;
	logic [DPLL_W-1:0]    dpll_state;
	logic [DPLL_W-1:0]    dpll_next;
	logic                 fs_ce_d;
	logic                 fs_ce_r1;
	logic                 fs_ce_r2;
	logic [RST_CNT_W-1:0] rst_cnt;

	assign o_line_state = line_state_e'(filt);
	assign o_line       = rx_line_t'{dp: filt[0], dn: filt[1], se0: filt == LS_SE0};

	always_ff @(posedge clk or negedge rst)
		if (!rst)
		begin
			sync0 <= LS_J;
			sync1 <= LS_J;
			filt  <= LS_J;
		end
		else
		begin
			sync0 <= {i_rxdn, i_rxdp};
			sync1 <= sync0;
			// A level has to be stable for two clocks to get through
			filt  <= (sync0 & sync1) | (filt & (sync0 | sync1));
		end

	////////////////////////////////////////////////////////////////////
	// DPLL, pulls the bit enable toward the middle of each bit
	assign change = lock_en && (rxd_r != filt[0]);

	always_comb
	begin
		fs_ce_d = dpll_state == DPLL_W'(1);
		case (dpll_state)
			DPLL_W'(0): dpll_next = change ? DPLL_W'(0) : DPLL_W'(1);
			DPLL_W'(1): dpll_next = change ? DPLL_W'(3) : DPLL_W'(2);
			DPLL_W'(2): dpll_next = change ? DPLL_W'(0) : DPLL_W'(3);
			default:    dpll_next = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
		if (!rst)
		begin
			rxd_r      <= 1'b1;
			lock_en    <= 1'b0;
			dpll_state <= DPLL_W'(1);
			fs_ce_r1   <= 1'b0;
			fs_ce_r2   <= 1'b0;
			o_fs_ce    <= 1'b0;
		end
		else
		begin
			rxd_r      <= filt[0];
			lock_en    <= i_rx_en;
			dpll_state <= dpll_next;
			// Three stages to match the input synchronizer delay
			fs_ce_r1   <= fs_ce_d;
			fs_ce_r2   <= fs_ce_r1;
			o_fs_ce    <= fs_ce_r2;
		end

	// Bus reset after a long run of SE0 bit times
	always_ff @(posedge clk or negedge rst)
		if (!rst)
		begin
			rst_cnt   <= '0;
			o_usb_rst <= 1'b0;
		end
		else
		begin
			if (o_line_state != LS_SE0)
				rst_cnt <= '0;
			else if (o_fs_ce && !(&rst_cnt))
				rst_cnt <= rst_cnt + RST_CNT_W'(1);
			o_usb_rst <= (o_line_state == LS_SE0) && (&rst_cnt);
		end

endmodule

//--- hdl/usb_tx_phy.sv
`timescale 1ns/10ps

module usb_tx_phy (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   i_fs_ce,
	input  usb_phy_pkg::utmi_tx_t  i_tx,
	output logic                   o_tx_ready,
	output usb_phy_pkg::usb_line_t o_line
);
	import usb_phy_pkg::*;

	localparam int ONE_W = $clog2(STUFF_RUN + 1);

	typedef enum logic [2:0] {IDLE, SOP, DATA, EOP1, EOP2, WAIT} tx_state_e;

	tx_state_e        state;
	tx_state_e        next_state;
	logic             tx_ready_d;
	logic             ld_sop_d;
	logic             ld_data_d;
	logic             ld_eop_d;
	logic             ld_data;
	logic             tx_ip;
	logic             tx_ip_sync;
	logic             data_done;
	logic [2:0]       bit_cnt;
	byte_t            hold_reg;
	byte_t            hold_reg_d;
	logic             sd_raw;
	logic             sft_done;
	logic             sft_done_r;
	logic             sft_done_e;
	logic [ONE_W-1:0] one_cnt;
	logic             stuff;
	logic             sd_bs;
	logic             sd_nrzi;
	logic             append_eop;
	logic [3:0]       eop_sync;
	logic             eop_done;
	logic             oe_r1;
	logic             oe_r2;

	assign stuff      = one_cnt == ONE_W'(STUFF_RUN);
	assign sft_done_e = sft_done & !sft_done_r;
	assign eop_done   = eop_sync[2];

	always_ff @(posedge clk or negedge rst)
		if (!rst)
		begin
			o_tx_ready <= 1'b0;
			ld_data    <= 1'b0;
			tx_ip      <= 1'b0;
			data_done  <= 1'b0;
		end
		else
		begin
			o_tx_ready <= tx_ready_d & i_tx.valid;
			ld_data    <= ld_data_d;
			if (ld_sop_d)
				tx_ip <= 1'b1;
			else if (eop_done)
				tx_ip <= 1'b0;
			// valid may drop and rise again before the current packet has left
			if (i_tx.valid && !tx_ip)
				data_done <= 1'b1;
			else if (!i_tx.valid)
				data_done <= 1'b0;
		end

	////////////////////////////////////////////////////////////////////
	// Shift register and bit stuffer
	always_ff @(posedge clk or negedge rst)
		if (!rst)
		begin
			tx_ip_sync <= 1'b0;
			bit_cnt    <= '0;
			one_cnt    <= '0;
			sd_raw     <= 1'b0;
			sft_done   <= 1'b0;
			sft_done_r <= 1'b0;
		end
		else
		begin
			if (i_fs_ce)
				tx_ip_sync <= tx_ip;
			sft_done   <= !stuff && bit_cnt == 3'd7;
			sft_done_r <= sft_done;
			if (!tx_ip_sync)
			begin
				bit_cnt <= '0;
				one_cnt <= '0;
				sd_raw  <= 1'b0;
			end
			else
			begin
				// LSB first
				sd_raw <= hold_reg_d[bit_cnt];
				if (i_fs_ce && !stuff)
					bit_cnt <= bit_cnt + 3'd1;
				if (i_fs_ce)
					one_cnt <= (!sd_raw || stuff) ? '0 : one_cnt + ONE_W'(1);
			end
		end

	always_ff @(posedge clk)
	begin
		if (ld_sop_d)
			hold_reg <= SYNC_BYTE;
		else if (ld_data)
			hold_reg <= i_tx.data;
		hold_reg_d <= hold_reg;
	end

	////////////////////////////////////////////////////////////////////
	// NRZI, end of packet and line drivers
	always_ff @(posedge clk or negedge rst)
		if (!rst)
		begin
			sd_bs      <= 1'b0;
			sd_nrzi    <= 1'b1;
			append_eop <= 1'b0;
			eop_sync   <= '0;
			oe_r1      <= 1'b0;
			oe_r2      <= 1'b0;
			o_line     <= usb_line_t'{dp: 1'b1, dn: 1'b0, oe_n: 1'b1};
		end
		else
		begin
			if (ld_eop_d)
				append_eop <= 1'b1;
			else if (eop_sync[1])
				append_eop <= 1'b0;
			// Idle J between packets, toggle on every zero
			if (!tx_ip_sync || !oe_r1)
				sd_nrzi <= 1'b1;
			else if (i_fs_ce)
				sd_nrzi <= sd_bs ? sd_nrzi : !sd_nrzi;
			if (i_fs_ce)
			begin
				sd_bs       <= tx_ip_sync && !stuff && sd_raw;
				eop_sync[0] <= append_eop;
				eop_sync[1] <= eop_sync[0];
				// Stage three stays up for exactly two bit times
				eop_sync[2] <= eop_sync[1] | (eop_sync[2] & !eop_sync[3]);
				eop_sync[3] <= eop_sync[2];
				oe_r1       <= tx_ip_sync;
				oe_r2       <= oe_r1;
				o_line.oe_n <= !(oe_r1 | oe_r2);
				o_line.dp   <= !eop_sync[2] & sd_nrzi;
				o_line.dn   <= !eop_sync[2] & !sd_nrzi;
			end
		end

	////////////////////////////////////////////////////////////////////
	// Packet FSM
	always_ff @(posedge clk or negedge rst)
		if (!rst)
			state <= IDLE;
		else
			state <= next_state;

	always_comb
	begin
		next_state = state;
		tx_ready_d = 1'b0;
		ld_sop_d   = 1'b0;
		ld_data_d  = 1'b0;
		ld_eop_d   = 1'b0;
		case (state)
			IDLE:
				if (i_tx.valid)
				begin
					ld_sop_d   = 1'b1;
					next_state = SOP;
				end
			SOP:
				if (sft_done_e)
				begin
					tx_ready_d = 1'b1;
					ld_data_d  = 1'b1;
					next_state = DATA;
				end
			DATA:
				if (sft_done_e && data_done)
				begin
					tx_ready_d = 1'b1;
					ld_data_d  = 1'b1;
				end
				else if (sft_done_e)
				begin
					ld_eop_d   = 1'b1;
					next_state = EOP1;
				end
			EOP1:
				if (eop_done)
					next_state = EOP2;
			EOP2:
				if (!eop_done && i_fs_ce)
					next_state = WAIT;
			WAIT:
				if (i_fs_ce)
					next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
	end

endmodule

//--- hdl/usb_phy_pkg.sv
package usb_phy_pkg;

	typedef logic [7:0] byte_t;

	// Bus state as {D-, D+}
	typedef enum logic [1:0] {
		LS_SE0 = 2'b00,
		LS_J   = 2'b01,
		LS_K   = 2'b10,
		LS_SE1 = 2'b11
	} line_state_e;

	// Link layer transmit request
	typedef struct packed {
		byte_t data;
		logic  valid;
	} utmi_tx_t;

	// Link layer receive result
	typedef struct packed {
		byte_t data;
		logic  valid;
		logic  active;
		logic  error;
	} utmi_rx_t;

	// Driven bus, oe_n low while the PHY owns the lines
	typedef struct packed {
		logic dp;
		logic dn;
		logic oe_n;
	} usb_line_t;

	// Filtered receive lines
	typedef struct packed {
		logic dp;
		logic dn;
		logic se0;
	} rx_line_t;

	localparam byte_t SYNC_BYTE = 8'h80;
	localparam int    STUFF_RUN = 6;
	localparam int    BIT_CLKS  = 4;

endpackage
